// File: tests/gnss_src_stim.txt
# write|busywrite <code|msg|ctrl> <channel> <addr> <data hex>, fill <target> <ch> <words> <base>
# strobe, run <ticks> <dense|random>, expect <carrier|freq|phase> <channel> <value hex>
expect carrier 0 076d5cfb
expect freq 1 0029e6ef
expect phase 0 00000000
fill code 0 32 3c5a9e17
fill code 1 32 81f0d2e4
write msg 0 0 0000000d
write msg 0 1 80000001
write msg 1 0 0000000a
write msg 1 1 7fff0000
run 3000 random
write ctrl 0 0 01234567
write ctrl 0 1 0029e700
write ctrl 0 2 00000011
write ctrl 0 3 00000005
write ctrl 1 0 076d0000
write ctrl 1 1 0029e6f0
write ctrl 1 2 000003ff
write ctrl 1 3 000003e8
strobe
expect carrier 0 01234567
expect freq 0 0029e700
expect phase 0 00000011
expect carrier 1 076d0000
expect phase 1 000003ff
busywrite ctrl 1 2 00000222
expect phase 1 000003ff
strobe
expect phase 1 00000222
run 2000 random
run 62000 dense

// File: sim.f
+incdir+common
common/gnss_src_pkg.sv
common/mem_wr_if.sv
hdl/host_write_port.sv
channel/code_player.sv
channel/msg_player.sv
hdl/param_loader.sv
hdl/gnss_src_top.sv
tests/tb_gnss_src.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_gnss_src
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_gnss_src.sv
`default_nettype none

`include "gnss_src_consts.svh"

module tb_gnss_src;
    timeunit 1ns;
    timeprecision 1ps;

    import gnss_src_pkg::*;

    localparam int WAIT_LIMIT = 20;  // Cycles a held write may wait for wr_ready

    logic                clk;
    logic                rst_n;
    logic                wr_valid;
    logic                wr_ready;
    wr_target_e          wr_target;
    ch_idx_t             wr_channel;
    wr_addr_t            wr_addr;
    word_t               wr_data;
    logic                param_strobe;
    logic                chip_tick;
    logic [`NUM_CH-1:0]  code_chip;
    logic [`NUM_CH-1:0]  msg_bit;
    word_t [`NUM_CH-1:0] carrier_freq;
    word_t [`NUM_CH-1:0] code_freq;
    word_t [`NUM_CH-1:0] code_phase;

    // --------------------------------------------------
    // Reference model state
    // --------------------------------------------------

    word_t                code_mdl [`NUM_CH][32];
    logic [`MSG_BITS-1:0] msg_mdl [`NUM_CH];
    word_t                ctrl_mdl [`NUM_CH][4];
    int                   delay_mdl [`NUM_CH];
    int                   wraps [`NUM_CH];  // Ticks that played the last chip of a period
    int                   tick_cnt;
    int                   seed;

    gnss_src_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_valid     (wr_valid),
        .wr_ready     (wr_ready),
        .wr_target    (wr_target),
        .wr_channel   (wr_channel),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .param_strobe (param_strobe),
        .chip_tick    (chip_tick),
        .code_chip    (code_chip),
        .msg_bit      (msg_bit),
        .carrier_freq (carrier_freq),
        .code_freq    (code_freq),
        .code_phase   (code_phase)
    );

    always #50 clk = ~clk;

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("error: %s", what);
        stop_on_failure();
    endtask

    task automatic check_value(input string name, input int ch, input word_t expected,
                               input word_t actual);
        if (actual !== expected) begin
            $display("mismatch %s ch%0d expected %h actual %h", name, ch, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic decode_target(input string name, output wr_target_e tgt);
        tgt = TGT_CODE;
        if (name == "code") begin
            tgt = TGT_CODE;
        end else if (name == "msg") begin
            tgt = TGT_MSG;
        end else if (name == "ctrl") begin
            tgt = TGT_CTRL;
        end else begin
            abort_run({"unknown write target ", name});
        end
    endtask

    // Holds the write until the handshake completes, then mirrors it in the model
    task automatic host_write(input wr_target_e tgt, input int ch, input int addr,
                              input word_t data);
        int waited;
        wr_valid   = 1'b1;
        wr_target  = tgt;
        wr_channel = ch_idx_t'(ch);
        wr_addr    = wr_addr_t'(addr);
        wr_data    = data;
        waited     = 0;
        while (wr_ready !== 1'b1) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("wr_ready stayed low while a write was held");
            end
            @(posedge clk);
            #1;
            waited++;
        end
        @(posedge clk);  // Accepted on this edge
        #1;
        wr_valid = 1'b0;
        case (tgt)
            TGT_CODE: code_mdl[ch][addr % 32] = data;
            TGT_MSG:  msg_mdl[ch][(addr % 2) * 32 +: 32] = data;
            default:  ctrl_mdl[ch][addr % 4] = data;
        endcase
        repeat (2) @(posedge clk);  // Let the write reach memory
        #1;
    endtask

    task automatic start_fetch();
        param_strobe = 1'b1;
        @(posedge clk);
        #1;
        param_strobe = 1'b0;
        // The fetch sees the control words as they stand at the strobe
        for (int c = 0; c < `NUM_CH; c++) begin
            delay_mdl[c] = int'(ctrl_mdl[c][CW_CODE_DELAY][9:0]);
        end
        check_value("wr_ready in fetch", 0, 32'd0, {31'd0, wr_ready});
    endtask

    task automatic pulse_strobe();
        int waited;
        start_fetch();
        waited = 0;
        while (wr_ready !== 1'b1) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("wr_ready did not come back after a parameter fetch");
            end
            @(posedge clk);
            #1;
            waited++;
        end
        // Every channel now carries the control words written before the strobe
        for (int c = 0; c < `NUM_CH; c++) begin
            check_value("carrier_freq after fetch", c, ctrl_mdl[c][CW_CARRIER_FREQ],
                        carrier_freq[c]);
            check_value("code_freq after fetch", c, ctrl_mdl[c][CW_CODE_FREQ], code_freq[c]);
            check_value("code_phase after fetch", c, ctrl_mdl[c][CW_CODE_PHASE],
                        code_phase[c]);
        end
    endtask

    task automatic tick_once();
        int p;
        int bit_idx;
        chip_tick = 1'b1;
        @(posedge clk);
        #1;
        chip_tick = 1'b0;
        for (int c = 0; c < `NUM_CH; c++) begin
            p       = ((tick_cnt % `CODE_LEN) - delay_mdl[c] + `CODE_LEN) % `CODE_LEN;
            bit_idx = (wraps[c] / `EPOCHS_PER_BIT) % `MSG_BITS;  // Earlier wraps only
            check_value("code_chip", c, {31'd0, code_mdl[c][p / 32][p % 32]},
                        {31'd0, code_chip[c]});
            check_value("msg_bit", c, {31'd0, msg_mdl[c][bit_idx]}, {31'd0, msg_bit[c]});
            if (p == `CODE_LEN - 1) begin
                wraps[c]++;
            end
        end
        tick_cnt++;
    endtask

    task automatic run_ticks(input int n, input bit dense);
        int gap;
        for (int i = 0; i < n; i++) begin
            tick_once();
            if (!dense) begin
                gap = $random(seed) & 3;
                if (gap > 0) begin
                    repeat (gap) @(posedge clk);
                    #1;
                end
            end
        end
    endtask

    initial begin
        int             fd;
        int             n_read;
        int             ch;
        int             addr;
        int             count;
        word_t          value;
        word_t          actual;
        string          cmd;
        string          arg;
        wr_target_e     tgt;
        reg [8*256-1:0] line;
        bit             done;

        clk          = 1'b0;
        rst_n        = 1'b0;
        wr_valid     = 1'b0;
        wr_target    = TGT_CODE;
        wr_channel   = '0;
        wr_addr      = '0;
        wr_data      = '0;
        param_strobe = 1'b0;
        chip_tick    = 1'b0;
        seed         = 32'h5e281a4b;
        tick_cnt     = 0;
        for (int c = 0; c < `NUM_CH; c++) begin
            delay_mdl[c] = 0;
            wraps[c]     = 0;
            msg_mdl[c]   = '0;
        end

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_value("wr_ready after reset", 0, 32'd1, {31'd0, wr_ready});
        for (int c = 0; c < `NUM_CH; c++) begin
            check_value("code_chip after reset", c, 32'd0, {31'd0, code_chip[c]});
            check_value("msg_bit after reset", c, 32'd0, {31'd0, msg_bit[c]});
        end

        // --------------------------------------------------
        // Command loop over the stim file
        // --------------------------------------------------

        fd = $fopen("tests/gnss_src_stim.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tests/gnss_src_stim.txt");
        end
        done = 1'b0;
        while (!done) begin
            n_read = $fscanf(fd, "%s", cmd);
            if (n_read != 1) begin
                done = 1'b1;
            end else if (cmd == "#") begin
                n_read = $fgets(line, fd);  // Rest of a comment line
            end else if (cmd == "write" || cmd == "busywrite") begin
                n_read = $fscanf(fd, "%s %d %d %h", arg, ch, addr, value);
                decode_target(arg, tgt);
                if (cmd == "busywrite") begin
                    start_fetch();  // The write is then held across the fetch
                end
                host_write(tgt, ch, addr, value);
            end else if (cmd == "fill") begin
                n_read = $fscanf(fd, "%s %d %d %h", arg, ch, count, value);
                decode_target(arg, tgt);
                for (int a = 0; a < count; a++) begin
                    host_write(tgt, ch, a, value ^ (a * 32'h9e3779b1));
                end
            end else if (cmd == "strobe") begin
                pulse_strobe();
            end else if (cmd == "run") begin
                n_read = $fscanf(fd, "%d %s", count, arg);
                run_ticks(count, arg == "dense");
            end else if (cmd == "expect") begin
                n_read = $fscanf(fd, "%s %d %h", arg, ch, value);
                if (ch >= `NUM_CH) begin
                    abort_run("expect line names a channel that does not exist");
                end
                if (arg == "carrier") begin
                    actual = carrier_freq[ch];
                end else if (arg == "freq") begin
                    actual = code_freq[ch];
                end else begin
                    actual = code_phase[ch];
                end
                check_value({"expect ", arg}, ch, value, actual);
            end else begin
                abort_run({"unknown command in stim file: ", cmd});
            end
        end
        $fclose(fd);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/gnss_src_top.sv
`default_nettype none

`include "gnss_src_consts.svh"

module gnss_src_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              wr_valid,
    output logic                              wr_ready,
    input  gnss_src_pkg::wr_target_e          wr_target,
    input  gnss_src_pkg::ch_idx_t             wr_channel,
    input  gnss_src_pkg::wr_addr_t            wr_addr,
    input  gnss_src_pkg::word_t               wr_data,
    input  logic                              param_strobe,
    input  logic                              chip_tick,
    output logic [`NUM_CH-1:0]                code_chip,
    output logic [`NUM_CH-1:0]                msg_bit,
    output gnss_src_pkg::word_t [`NUM_CH-1:0] carrier_freq,
    output gnss_src_pkg::word_t [`NUM_CH-1:0] code_freq,
    output gnss_src_pkg::word_t [`NUM_CH-1:0] code_phase
);
    import gnss_src_pkg::*;

    chip_idx_t [`NUM_CH-1:0] code_delay;
    logic      [`NUM_CH-1:0] epoch;  // Code period wrap, one per channel
    logic                    fetch_busy;

    mem_wr_if wr_bus ();

    host_write_port u_host_write_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_valid   (wr_valid),
        .wr_ready   (wr_ready),
        .wr_target  (wr_target),
        .wr_channel (wr_channel),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .fetch_busy (fetch_busy),
        .wr         (wr_bus.host)
    );

    param_loader u_param_loader (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr           (wr_bus.mem),
        .param_strobe (param_strobe),
        .fetch_busy   (fetch_busy),
        .carrier_freq (carrier_freq),
        .code_freq    (code_freq),
        .code_phase   (code_phase),
        .code_delay   (code_delay)
    );

    // --------------------------------------------------
    // Per-channel players
    // --------------------------------------------------

    for (genvar ch = 0; ch < `NUM_CH; ch++) begin : g_ch
        code_player #(.CHANNEL(ch)) u_code_player (
            .clk        (clk),
            .rst_n      (rst_n),
            .wr         (wr_bus.mem),
            .chip_tick  (chip_tick),
            .code_delay (code_delay[ch]),
            .code_chip  (code_chip[ch]),
            .epoch      (epoch[ch])
        );

        msg_player #(.CHANNEL(ch)) u_msg_player (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr      (wr_bus.mem),
            .epoch   (epoch[ch]),
            .msg_bit (msg_bit[ch])
        );
    end

endmodule

`default_nettype wire

// File: hdl/param_loader.sv
`default_nettype none

`include "gnss_src_consts.svh"

module param_loader (
    input  logic                                  clk,
    input  logic                                  rst_n,
    mem_wr_if.mem                                 wr,
    input  logic                                  param_strobe,
    output logic                                  fetch_busy,
    output gnss_src_pkg::word_t     [`NUM_CH-1:0] carrier_freq,
    output gnss_src_pkg::word_t     [`NUM_CH-1:0] code_freq,
    output gnss_src_pkg::word_t     [`NUM_CH-1:0] code_phase,
    output gnss_src_pkg::chip_idx_t [`NUM_CH-1:0] code_delay
);
    import gnss_src_pkg::*;

    word_t        ctrl_mem [`NUM_CH][4];  // Four control words per channel
    word_t        carrier_stage [`NUM_CH];
    word_t        freq_stage [`NUM_CH];
    word_t        phase_stage [`NUM_CH];
    chip_idx_t    delay_stage [`NUM_CH];
    fetch_state_e state;
    fetch_state_e state_nxt;
    ctrl_word_e   rd_sel;

    always_ff @(posedge clk) begin
        if (wr.en && (wr.target == TGT_CTRL)) begin
            for (int c = 0; c < `NUM_CH; c++) begin
                if (wr.channel == ch_idx_t'(c)) begin
                    ctrl_mem[c][wr.addr[1:0]] <= wr.data;
                end
            end
        end
    end

    // --------------------------------------------------
    // Fetch FSM
    // --------------------------------------------------

    always_comb begin
        case (state)
            FETCH_IDLE:    state_nxt = param_strobe ? FETCH_CARRIER : FETCH_IDLE;
            FETCH_CARRIER: state_nxt = FETCH_FREQ;
            FETCH_FREQ:    state_nxt = FETCH_PHASE;
            FETCH_PHASE:   state_nxt = FETCH_DELAY;
            FETCH_DELAY:   state_nxt = FETCH_DONE;
            default:       state_nxt = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FETCH_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign fetch_busy = (state != FETCH_IDLE);

    // Word address read in each fetch state
    always_comb begin
        case (state)
            FETCH_CARRIER: rd_sel = CW_CARRIER_FREQ;
            FETCH_FREQ:    rd_sel = CW_CODE_FREQ;
            FETCH_PHASE:   rd_sel = CW_CODE_PHASE;
            default:       rd_sel = CW_CODE_DELAY;
        endcase
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < `NUM_CH; c++) begin
            case (state)
                FETCH_CARRIER: carrier_stage[c] <= ctrl_mem[c][rd_sel];
                FETCH_FREQ:    freq_stage[c]    <= ctrl_mem[c][rd_sel];
                FETCH_PHASE:   phase_stage[c]   <= ctrl_mem[c][rd_sel];
                FETCH_DELAY:   delay_stage[c]   <= ctrl_mem[c][rd_sel][9:0];
                default: ;
            endcase
        end
    end

    // --------------------------------------------------
    // Parameter registers
    // --------------------------------------------------

    // All channels switch to the new words on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < `NUM_CH; c++) begin
                carrier_freq[c] <= `CARRIER_FREQ_RST;
                code_freq[c]    <= `CODE_FREQ_RST;
                code_phase[c]   <= '0;
                code_delay[c]   <= '0;
            end
        end else if (state == FETCH_DONE) begin
            for (int c = 0; c < `NUM_CH; c++) begin
                carrier_freq[c] <= carrier_stage[c];
                code_freq[c]    <= freq_stage[c];
                code_phase[c]   <= phase_stage[c];
                code_delay[c]   <= delay_stage[c];
            end
        end
    end

    // The write port must hold control writes back while the FSM owns the memory
    a_no_ctrl_write_in_fetch : assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr.en && (wr.target == TGT_CTRL)) |-> !fetch_busy
    );

endmodule

`default_nettype wire

// File: channel/msg_player.sv
`default_nettype none

`include "gnss_src_consts.svh"

module msg_player #(
    parameter int CHANNEL = 0
) (
    input  logic  clk,
    input  logic  rst_n,
    mem_wr_if.mem wr,
    input  logic  epoch,
    output logic  msg_bit
);
    import gnss_src_pkg::*;

    localparam int EPOCH_W = $clog2(`EPOCHS_PER_BIT);
    localparam int PTR_W   = $clog2(`MSG_BITS);

    logic [`MSG_BITS-1:0] msg_bits;   // Word 0 in the low half
    logic [EPOCH_W-1:0]   epoch_cnt;  // Code periods spent on the current bit
    logic [PTR_W-1:0]     bit_ptr;
    logic                 msg_wr;

    assign msg_wr = wr.en && (wr.target == TGT_MSG) && (wr.channel == ch_idx_t'(CHANNEL));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msg_bits <= '0;
        end else if (msg_wr) begin
            msg_bits[{wr.addr[0], 5'd0} +: 32] <= wr.data;
        end
    end

    // --------------------------------------------------
    // Bit sequencer
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            epoch_cnt <= '0;
            bit_ptr   <= '0;
        end else if (epoch) begin
            if (epoch_cnt == EPOCH_W'(`EPOCHS_PER_BIT - 1)) begin
                epoch_cnt <= '0;
                // Plain ring over the whole message
                if (bit_ptr == PTR_W'(`MSG_BITS - 1)) begin
                    bit_ptr <= '0;
                end else begin
                    bit_ptr <= bit_ptr + 1'b1;
                end
            end else begin
                epoch_cnt <= epoch_cnt + 1'b1;
            end
        end
    end

    assign msg_bit = msg_bits[bit_ptr];  // Changes with the first chip of a new bit

endmodule

`default_nettype wire

// File: channel/code_player.sv
`default_nettype none

`include "gnss_src_consts.svh"

module code_player #(
    parameter int CHANNEL = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    mem_wr_if.mem                   wr,
    input  logic                    chip_tick,
    input  gnss_src_pkg::chip_idx_t code_delay,
    output logic                    code_chip,
    output logic                    epoch
);
    import gnss_src_pkg::*;

    localparam chip_idx_t LAST_CHIP = chip_idx_t'(`CODE_LEN - 1);

    word_t     code_mem [32];  // Chips LSB-first, word 0 holds chips 0..31
    chip_idx_t chip_cnt;       // Undelayed index of the next chip to play
    chip_idx_t rd_idx;         // Delayed index actually read
    logic      code_wr;

    assign code_wr = wr.en && (wr.target == TGT_CODE) && (wr.channel == ch_idx_t'(CHANNEL));

    always_ff @(posedge clk) begin
        if (code_wr) begin
            code_mem[wr.addr] <= wr.data;
        end
    end

    // --------------------------------------------------
    // Chip counter and delayed readout
    // --------------------------------------------------

    // Subtract the delay modulo CODE_LEN
    always_comb begin
        if (chip_cnt >= code_delay) begin
            rd_idx = chip_cnt - code_delay;
        end else begin
            rd_idx = chip_cnt + (chip_idx_t'(`CODE_LEN) - code_delay);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chip_cnt  <= '0;
            code_chip <= 1'b0;
            epoch     <= 1'b0;
        end else begin
            epoch <= chip_tick && (rd_idx == LAST_CHIP);  // Last chip of a period goes out
            if (chip_tick) begin
                code_chip <= code_mem[rd_idx[9:5]][rd_idx[4:0]];
                if (chip_cnt == LAST_CHIP) begin
                    chip_cnt <= '0;
                end else begin
                    chip_cnt <= chip_cnt + 1'b1;
                end
            end
        end
    end

    // A delay of CODE_LEN or more would read past the end of the code
    a_delay_in_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        code_delay < chip_idx_t'(`CODE_LEN)
    );

endmodule

`default_nettype wire

// File: hdl/host_write_port.sv
`default_nettype none

`include "gnss_src_consts.svh"

module host_write_port (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_valid,
    output logic                     wr_ready,
    input  gnss_src_pkg::wr_target_e wr_target,
    input  gnss_src_pkg::ch_idx_t    wr_channel,
    input  gnss_src_pkg::wr_addr_t   wr_addr,
    input  gnss_src_pkg::word_t      wr_data,
    input  logic                     fetch_busy,
    mem_wr_if.host                   wr
);

    logic accept;

    // The control memory has one port, so writes wait out a fetch
    assign wr_ready = ~fetch_busy;
    assign accept   = wr_valid & wr_ready;

    // --------------------------------------------------
    // Write strobe and payload register
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr.en <= 1'b0;
        end else begin
            wr.en <= accept;  // High for exactly one cycle per accepted write
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr.target  <= wr_target;
            wr.channel <= wr_channel;
            wr.addr    <= wr_addr;
            wr.data    <= wr_data;
        end
    end

    // Writes to channels that do not exist would be dropped by every memory
    a_channel_in_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        accept |-> (wr_channel < `NUM_CH)
    );

endmodule

`default_nettype wire

// File: common/mem_wr_if.sv
`default_nettype none

// One accepted host write, broadcast to every memory in the design
interface mem_wr_if;
    import gnss_src_pkg::*;

    logic       en;       // One cycle per accepted write
    wr_target_e target;
    ch_idx_t    channel;
    wr_addr_t   addr;
    word_t      data;

    modport host (
        output en,
        output target,
        output channel,
        output addr,
        output data
    );

    // Each memory decodes target and channel on its own
    modport mem (
        input en,
        input target,
        input channel,
        input addr,
        input data
    );

endinterface

`default_nettype wire

// File: common/gnss_src_pkg.sv
`default_nettype none

package gnss_src_pkg;

    typedef logic [31:0] word_t;      // Host data and control word
    typedef logic [4:0]  wr_addr_t;   // Word address inside one target memory
    typedef logic [9:0]  chip_idx_t;  // Chip index inside a code period
    typedef logic [2:0]  ch_idx_t;    // Channel number

    // Memory that a host write lands in
    typedef enum logic [1:0] {
        TGT_CODE,
        TGT_MSG,
        TGT_CTRL
    } wr_target_e;

    // Word addresses inside one channel's control memory
    typedef enum logic [1:0] {
        CW_CARRIER_FREQ = 2'd0,
        CW_CODE_FREQ    = 2'd1,
        CW_CODE_PHASE   = 2'd2,
        CW_CODE_DELAY   = 2'd3
    } ctrl_word_e;

    // Control word fetch sequence, one word per state
    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_CARRIER,
        FETCH_FREQ,
        FETCH_PHASE,
        FETCH_DELAY,
        FETCH_DONE
    } fetch_state_e;

endpackage

`default_nettype wire

// File: common/gnss_src_consts.svh
`ifndef GNSS_SRC_CONSTS_SVH
`define GNSS_SRC_CONSTS_SVH

// --------------------------------------------------
// Channel and sequence sizes
// --------------------------------------------------

// Number of active channels
`define NUM_CH 2

// Chips in one spreading code period
`define CODE_LEN 1023

// Message bits held per channel, played as a ring
`define MSG_BITS 64

`define EPOCHS_PER_BIT 20  // Code periods per message bit

// --------------------------------------------------
// Parameter register reset values
// --------------------------------------------------

`define CARRIER_FREQ_RST 32'd124607739  // Nominal carrier NCO word
`define CODE_FREQ_RST 32'd2746095       // Nominal chip rate NCO word

`endif
